/* sim.f */
cpu_pkg.sv
idu.sv
alu.sv
branch_unit.sv
exu.sv
ex_top.sv
tb_ex_top.sv

/* run.sh */
#!/bin/sh
# build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_ex_top -o tb_ex_top \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ex_top > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

/* tb_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

	localparam int NUM_INSTR  = 400;
	localparam int MAX_CYCLES = NUM_INSTR * 8;

	logic        clock;
	logic        rst_n;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] csr_val;
	logic        csr_jump_en;
	logic [31:0] csr_jump;
	logic        in_valid;
	logic        out_ready;
	wire         in_ready;
	wire         out_valid;
	wire         jump_wrong;
	wire         illegal_instr;
	wire cpu_pkg::exu_result_t result;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          cycles;
	int          issued;
	int          cls;
	logic        is_ecall;
	logic [31:0] imm;
	cpu_pkg::exu_result_t exp_q[$]; // results still owed by the DUT

	ex_top dut (
		.clock (clock), .rst_n (rst_n), .instr (instr), .pc (pc),
		.src1 (src1), .src2 (src2), .csr_val (csr_val),
		.csr_jump_en (csr_jump_en), .csr_jump (csr_jump),
		.in_valid (in_valid), .in_ready (in_ready),
		.out_valid (out_valid), .out_ready (out_ready),
		.result (result), .jump_wrong (jump_wrong), .illegal_instr (illegal_instr)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: %0d of %0d instructions issued after %0d cycles",
				issued, NUM_INSTR, cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic known_opcode(input logic [6:0] o);
		return o inside {cpu_pkg::OPC_LUI, cpu_pkg::OPC_AUIPC, cpu_pkg::OPC_JAL,
			cpu_pkg::OPC_JALR, cpu_pkg::OPC_BRANCH, cpu_pkg::OPC_LOAD, cpu_pkg::OPC_STORE,
			cpu_pkg::OPC_OPIMM, cpu_pkg::OPC_OP, cpu_pkg::OPC_SYSTEM};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_result(input cpu_pkg::exu_result_t exp);
		compare("result.val", result.val, exp.val);
		compare("result.csr_val", result.csr_val, exp.csr_val);
		compare("result.pc", result.pc, exp.pc);
		compare("result.csr_wdata", result.csr_wdata, exp.csr_wdata);
		compare("result.lsu_data", result.lsu_data, exp.lsu_data);
		compare("result.jump_addr", result.jump_addr, exp.jump_addr);
		compare("result.rd", 32'(result.rd), 32'(exp.rd));
		compare("result.funct3", 32'(result.funct3), 32'(exp.funct3));
		compare("result.csr_imm", 32'(result.csr_imm), 32'(exp.csr_imm));
		compare("result.reg_wen", 32'(result.reg_wen), 32'(exp.reg_wen));
		compare("result.lsu_ren", 32'(result.lsu_ren), 32'(exp.lsu_ren));
		compare("result.lsu_wen", 32'(result.lsu_wen), 32'(exp.lsu_wen));
		compare("result.csr_enable", 32'(result.csr_enable), 32'(exp.csr_enable));
		compare("result.jal_enable", 32'(result.jal_enable), 32'(exp.jal_enable));
		compare("result.ecall", 32'(result.ecall), 32'(exp.ecall));
	endtask

	// reference model on the operands now driven
	function automatic cpu_pkg::exu_result_t expected_result();
		cpu_pkg::exu_result_t r;
		logic [31:0] lhs;
		logic [31:0] rhs;
		logic [2:0]  f3;
		logic        alt;
		logic        cond;
		f3  = instr[14:12];
		alt = instr[30];
		r            = '0;
		r.csr_val    = csr_val;
		r.pc         = pc;
		r.lsu_data   = src2;
		r.rd         = instr[10:7];
		r.funct3     = f3;
		r.csr_imm    = imm[11:0];
		r.csr_wdata  = (f3 == 3'b001) ? src1 : (f3 == 3'b010) ? (src1 | csr_val) : 32'b0;
		r.lsu_ren    = (cls == cpu_pkg::INST_LW);
		r.lsu_wen    = (cls == cpu_pkg::INST_SW);
		r.csr_enable = (cls == cpu_pkg::INST_CSR) && (f3 != 3'b000);
		r.jal_enable = (cls == cpu_pkg::INST_JAL) || (cls == cpu_pkg::INST_JALR);
		r.ecall      = is_ecall;
		r.reg_wen    = !((cls == cpu_pkg::INST_BRANCH) || (cls == cpu_pkg::INST_SW) ||
			((cls == cpu_pkg::INST_CSR) && (f3 == 3'b000)));
		if (cls == cpu_pkg::INST_AUIPC || cls == cpu_pkg::INST_JAL || cls == cpu_pkg::INST_BRANCH)
			lhs = pc;
		else if (cls == cpu_pkg::INST_LUI)
			lhs = 32'b0;
		else
			lhs = src1;
		rhs   = (cls == cpu_pkg::INST_OP) ? src2 : imm;
		r.val = lhs + rhs;
		if (cls == cpu_pkg::INST_OP || cls == cpu_pkg::INST_OPIMM) begin
			case (f3)
				3'b000: if (cls == cpu_pkg::INST_OP && alt) r.val = lhs - rhs;
				3'b001: r.val = lhs << rhs[4:0];
				3'b010: r.val = {31'b0, $signed(lhs) < $signed(rhs)};
				3'b011: r.val = {31'b0, lhs < rhs};
				3'b100: r.val = lhs ^ rhs;
				3'b101: begin
					if (alt) r.val = $signed(lhs) >>> rhs[4:0];
					else r.val = lhs >> rhs[4:0];
				end
				3'b110: r.val = lhs | rhs;
				default: r.val = lhs & rhs;
			endcase
		end
		case (f3)
			3'b000: cond = (src1 == src2);
			3'b001: cond = (src1 != src2);
			3'b100: cond = ($signed(src1) < $signed(src2));
			3'b101: cond = ($signed(src1) >= $signed(src2));
			3'b110: cond = (src1 < src2);
			default: cond = (src1 >= src2);
		endcase
		if (csr_jump_en)
			r.jump_addr = csr_jump;
		else if (r.jal_enable || (cls == cpu_pkg::INST_BRANCH && cond))
			r.jump_addr = lhs + rhs;
		else
			r.jump_addr = pc + 32'd4;
		return r;
	endfunction

	task automatic make_illegal();
		logic [31:0] r;
		r = random_bits(7);
		while (known_opcode(r[6:0])) r = random_bits(7);
		instr[6:0] = r[6:0];
		r = random_bits(25);
		instr[31:7] = r[24:0];
	endtask

	task automatic make_instr();
		logic [31:0] r;
		logic [4:0]  rd5;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] i12;
		logic [2:0]  f3;
		logic        alt;
		r   = random_bits(12);
		rd5 = {1'b0, r[3:0]}; // 16 registers
		rs1 = {1'b0, r[7:4]};
		rs2 = {1'b0, r[11:8]};
		r   = random_bits(12);
		i12 = r[11:0];
		r   = random_bits(4);
		f3  = r[2:0];
		alt = r[3];
		cls = int'(random_bits(8) % 10);
		is_ecall = 1'b0;
		r = random_bits(20);
		case (cls)
			cpu_pkg::INST_LUI, cpu_pkg::INST_AUIPC: begin
				instr = {r[19:0], rd5,
					(cls == cpu_pkg::INST_LUI) ? cpu_pkg::OPC_LUI : cpu_pkg::OPC_AUIPC};
				imm = {r[19:0], 12'b0};
			end
			cpu_pkg::INST_JAL: begin
				// r holds offset bits 20:1
				instr = {r[19], r[9:0], r[10], r[18:11], rd5, cpu_pkg::OPC_JAL};
				imm   = {{11{r[19]}}, r[19:0], 1'b0};
			end
			cpu_pkg::INST_BRANCH: begin
				f3 = 3'(r[19:12] % 6);
				if (f3 > 3'd1) f3 = f3 + 3'd2; // skip 010 and 011
				instr = {i12[11], i12[9:4], rs2, rs1, f3, i12[3:0], i12[10], cpu_pkg::OPC_BRANCH};
				imm   = {{19{i12[11]}}, i12, 1'b0};
			end
			cpu_pkg::INST_SW: begin
				instr = {i12[11:5], rs2, rs1, 3'b010, i12[4:0], cpu_pkg::OPC_STORE};
				imm   = {{20{i12[11]}}, i12};
			end
			cpu_pkg::INST_OP: begin
				instr = {1'b0, alt & (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd5,
					cpu_pkg::OPC_OP};
				imm = 32'b0;
			end
			cpu_pkg::INST_CSR: begin
				case (f3[1:0])
					2'd0: instr = {i12, rs1, 3'b001, rd5, cpu_pkg::OPC_SYSTEM};
					2'd1: instr = {i12, rs1, 3'b010, rd5, cpu_pkg::OPC_SYSTEM};
					2'd2: instr = cpu_pkg::ECALL_WORD;
					default: instr = cpu_pkg::MRET_WORD;
				endcase
				is_ecall = (f3[1:0] == 2'd2);
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			default: begin
				// i-type jalr, lw and op-imm
				if (cls == cpu_pkg::INST_OPIMM && f3 == 3'b001) i12 = {7'b0, i12[4:0]};
				if (cls == cpu_pkg::INST_OPIMM && f3 == 3'b101) i12 = {1'b0, alt, 5'b0, i12[4:0]};
				if (cls == cpu_pkg::INST_JALR) f3 = 3'b000;
				if (cls == cpu_pkg::INST_LW) f3 = 3'b010;
				instr = {i12, rs1, f3, rd5, (cls == cpu_pkg::INST_JALR) ? cpu_pkg::OPC_JALR :
					(cls == cpu_pkg::INST_LW) ? cpu_pkg::OPC_LOAD : cpu_pkg::OPC_OPIMM};
				imm = {{20{i12[11]}}, i12};
			end
		endcase
		r       = random_bits(30);
		pc      = {r[29:0], 2'b00};
		src1    = random_bits(32);
		src2    = random_bits(32);
		csr_val = random_bits(32);
		r       = random_bits(5);
		if (cls == cpu_pkg::INST_BRANCH && r[1:0] == 2'd0) src2 = src1; // equal operands
		csr_jump_en = (r[4:2] == 3'd0);
		r        = random_bits(30);
		csr_jump = {r[29:0], 2'b00};
	endtask

	initial begin
		logic        pending;
		logic        ill_check;
		logic        p_valid;
		logic        p_ready;
		logic        p_ovalid;
		logic        p_oready;
		logic [31:0] r;
		cpu_pkg::exu_result_t pend_exp;
		errors = 0;
		checks = 0;
		cycles = 0;
		issued = 0;
		lfsr = 32'h685b5ef0;
		rst_n = 1'b0;
		instr = '0;
		pc = '0;
		src1 = '0;
		src2 = '0;
		csr_val = '0;
		csr_jump_en = 1'b0;
		csr_jump = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		pending = 1'b0;
		ill_check = 1'b0;
		p_valid = 1'b0;
		p_ready = 1'b0;
		p_ovalid = 1'b0;
		p_oready = 1'b0;
		pend_exp = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		compare("in_ready", 32'(in_ready), 32'd1);
		compare("out_valid", 32'(out_valid), 32'd0);
		compare("jump_wrong", 32'(jump_wrong), 32'd0);
		while (issued < NUM_INSTR || exp_q.size() != 0) begin
			@(negedge clock);
			// replay the handshakes of the last rising edge
			if (p_ovalid && p_oready && exp_q.size() != 0) void'(exp_q.pop_front());
			if (p_valid && p_ready) begin
				exp_q.push_back(pend_exp);
				compare("jump_wrong", 32'(jump_wrong),
					32'(pend_exp.jump_addr != pend_exp.pc + 32'd4));
				pending = 1'b0;
				issued++;
			end else begin
				compare("jump_wrong", 32'(jump_wrong), 32'd0);
			end
			if (exp_q.size() > 1) begin
				errors++;
				$display("error at %0t ns: a new instruction was taken before the last result left",
					$time);
				void'(exp_q.pop_front());
			end
			compare("out_valid", 32'(out_valid), 32'(exp_q.size() != 0));
			compare("in_ready", 32'(in_ready), 32'(exp_q.size() == 0));
			if (out_valid && exp_q.size() != 0) check_result(exp_q[0]);
			if (ill_check) compare("illegal_instr", 32'(illegal_instr), 32'd1);
			else if (pending) compare("illegal_instr", 32'(illegal_instr), 32'd0);
			ill_check = 1'b0;
			if (!pending && issued < NUM_INSTR) begin
				r = random_bits(3);
				if (r[2:0] == 3'd0) begin
					make_illegal(); // shown for one cycle and never valid
					ill_check = 1'b1;
				end else begin
					make_instr();
					pend_exp = expected_result();
					pending  = 1'b1;
				end
			end
			in_valid  = pending;
			r         = random_bits(8);
			out_ready = ((r % 3) != 0); // low about a third of the time
			p_valid   = in_valid;
			p_ready   = in_ready;
			p_ovalid  = out_valid;
			p_oready  = out_ready;
		end
		$display("%0d errors in %0d checks over %0d instructions", errors, checks, issued);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top (
	input  wire                        clock,
	input  wire                        rst_n,
	input  wire [31:0]                 instr,
	input  wire [31:0]                 pc,
	input  wire [31:0]                 src1,
	input  wire [31:0]                 src2,
	input  wire [31:0]                 csr_val,
	input  wire                        csr_jump_en,
	input  wire [31:0]                 csr_jump,
	input  wire                        in_valid,
	output wire                        in_ready,
	output wire                        out_valid,
	input  wire                        out_ready,
	output wire cpu_pkg::exu_result_t  result,
	output wire                        jump_wrong,
	output wire                        illegal_instr
);

	wire cpu_pkg::decoded_t dec;

	idu u_idu (
		.instr   (instr),
		.dec     (dec),
		.illegal (illegal_instr)
	);

	exu u_exu (
		.clock       (clock),
		.rst_n       (rst_n),
		.dec         (dec),
		.pc          (pc),
		.src1        (src1),
		.src2        (src2),
		.csr_val     (csr_val),
		.csr_jump    (csr_jump),
		.csr_jump_en (csr_jump_en),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.result      (result),
		.jump_wrong  (jump_wrong)
	);

endmodule

`default_nettype wire

/* exu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu (
	input  wire                       clock,
	input  wire                       rst_n,
	input  wire cpu_pkg::decoded_t    dec,
	input  wire [31:0]                pc,
	input  wire [31:0]                src1,
	input  wire [31:0]                src2,
	input  wire [31:0]                csr_val,
	input  wire [31:0]                csr_jump,
	input  wire                       csr_jump_en,
	input  wire                       in_valid,
	output logic                      in_ready,
	output logic                      out_valid,
	input  wire                       out_ready,
	output cpu_pkg::exu_result_t      result,
	output logic                      jump_wrong
);

	logic                 accept;
	logic                 drain;
	logic [31:0]          alu_sum;
	logic [31:0]          alu_val;
	logic [31:0]          next_pc;
	logic                 mispredict;
	logic [31:0]          csr_wdata;
	cpu_pkg::exu_result_t res_d;

	alu u_alu (
		.dec  (dec),
		.pc   (pc),
		.src1 (src1),
		.src2 (src2),
		.sum  (alu_sum),
		.val  (alu_val)
	);

	branch_unit u_branch (
		.dec         (dec),
		.pc          (pc),
		.src1        (src1),
		.src2        (src2),
		.target      (alu_sum),
		.csr_jump    (csr_jump),
		.csr_jump_en (csr_jump_en),
		.next_pc     (next_pc),
		.mispredict  (mispredict)
	);

	assign accept = in_valid & in_ready;
	assign drain  = out_valid & out_ready;

	always_comb begin
		case (dec.funct3)
			3'b001:  csr_wdata = src1;           // csrrw
			3'b010:  csr_wdata = src1 | csr_val; // csrrs
			default: csr_wdata = 32'b0;
		endcase
	end

	always_comb begin
		res_d            = '0;
		res_d.val        = alu_val;
		res_d.csr_val    = csr_val;
		res_d.pc         = pc;
		res_d.csr_wdata  = csr_wdata;
		res_d.lsu_data   = src2; // store data
		res_d.jump_addr  = next_pc;
		res_d.rd         = dec.rd;
		res_d.funct3     = dec.funct3;
		res_d.csr_imm    = dec.imm[11:0];
		res_d.reg_wen    = dec.reg_wen;
		res_d.lsu_ren    = dec.inst_class[cpu_pkg::INST_LW];
		res_d.lsu_wen    = dec.inst_class[cpu_pkg::INST_SW];
		res_d.csr_enable = dec.inst_class[cpu_pkg::INST_CSR] & (dec.funct3 != 3'b000);
		res_d.jal_enable = dec.inst_class[cpu_pkg::INST_JAL] | dec.inst_class[cpu_pkg::INST_JALR];
		res_d.ecall      = dec.is_ecall;
	end

	// one instruction in flight
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			in_ready   <= 1'b1;
			out_valid  <= 1'b0;
			jump_wrong <= 1'b0;
		end else begin
			if (accept) begin
				in_ready  <= 1'b0;
				out_valid <= 1'b1;
			end else if (drain) begin
				in_ready  <= 1'b1;
				out_valid <= 1'b0;
			end
			jump_wrong <= accept & mispredict; // single cycle pulse
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			result <= res_d;
		end
	end

	a_ready_valid_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(in_ready && out_valid));

	// decoder must hand over a clean class vector
	a_class_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		in_valid |-> $onehot0(dec.inst_class));

	a_jump_wrong_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		jump_wrong |=> !jump_wrong);

endmodule

`default_nettype wire

/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  wire cpu_pkg::decoded_t dec,
	input  wire [31:0]             pc,
	input  wire [31:0]             src1,
	input  wire [31:0]             src2,
	input  wire [31:0]             target,
	input  wire [31:0]             csr_jump,
	input  wire                    csr_jump_en,
	output logic [31:0]            next_pc,
	output logic                   mispredict
);

	logic [32:0] diff;
	logic [31:0] snpc;
	logic        eq;
	logic        lt;
	logic        ltu;
	logic        cond;
	logic        take;

	// one subtractor for all six compares
	assign diff = {1'b0, src1} - {1'b0, src2};
	assign eq   = (diff[31:0] == 32'b0);
	assign ltu  = diff[32]; // borrow
	assign lt   = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & diff[31]);

	always_comb begin
		case (dec.funct3)
			3'b000:  cond = eq;
			3'b001:  cond = ~eq;
			3'b100:  cond = lt;
			3'b101:  cond = ~lt;
			3'b110:  cond = ltu;
			3'b111:  cond = ~ltu;
			default: cond = 1'b0;
		endcase
	end

	assign take = dec.inst_class[cpu_pkg::INST_JAL] | dec.inst_class[cpu_pkg::INST_JALR] |
		(dec.inst_class[cpu_pkg::INST_BRANCH] & cond);

	assign snpc = pc + 32'd4;

	// trap redirect wins over everything
	assign next_pc = csr_jump_en ? csr_jump :
		take ? target :
		snpc;

	assign mispredict = (next_pc != snpc);

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::decoded_t dec,
	input  wire [31:0]             pc,
	input  wire [31:0]             src1,
	input  wire [31:0]             src2,
	output logic [31:0]            sum,
	output logic [31:0]            val
);

	logic [31:0] lhs;
	logic [31:0] rhs;
	logic [31:0] diff;
	logic [4:0]  shamt;
	logic [3:0]  op;

	assign lhs = (dec.inst_class[cpu_pkg::INST_AUIPC] | dec.inst_class[cpu_pkg::INST_JAL] |
		dec.inst_class[cpu_pkg::INST_BRANCH]) ? pc :
		dec.inst_class[cpu_pkg::INST_LUI] ? 32'b0 :
		src1;
	assign rhs = dec.inst_class[cpu_pkg::INST_OP] ? src2 : dec.imm;

	assign sum   = lhs + rhs; // also the jump target
	assign diff  = lhs - rhs;
	assign shamt = rhs[4:0];

	always_comb begin
		op = cpu_pkg::OP_ADD;
		if (dec.inst_class[cpu_pkg::INST_OPIMM] | dec.inst_class[cpu_pkg::INST_OP]) begin
			case (dec.funct3)
				3'b000: begin
					// addi ignores imm bit 10
					if (dec.inst_class[cpu_pkg::INST_OP] && dec.funct7_b5) begin
						op = cpu_pkg::OP_SUB;
					end else begin
						op = cpu_pkg::OP_ADD;
					end
				end
				3'b001: op = cpu_pkg::OP_SLL;
				3'b010: op = cpu_pkg::OP_LESS;
				3'b011: op = cpu_pkg::OP_ULESS;
				3'b100: op = cpu_pkg::OP_XOR;
				3'b101: op = dec.funct7_b5 ? cpu_pkg::OP_SRA : cpu_pkg::OP_SRL;
				3'b110: op = cpu_pkg::OP_OR;
				default: op = cpu_pkg::OP_AND;
			endcase
		end
	end

	always_comb begin
		case (op)
			cpu_pkg::OP_SUB:   val = diff;
			cpu_pkg::OP_AND:   val = lhs & rhs;
			cpu_pkg::OP_XOR:   val = lhs ^ rhs;
			cpu_pkg::OP_OR:    val = lhs | rhs;
			cpu_pkg::OP_SRL:   val = lhs >> shamt;
			cpu_pkg::OP_SRA:   val = $signed(lhs) >>> shamt;
			cpu_pkg::OP_SLL:   val = lhs << shamt;
			cpu_pkg::OP_LESS:  val = {31'b0, $signed(lhs) < $signed(rhs)};
			cpu_pkg::OP_ULESS: val = {31'b0, lhs < rhs};
			default:           val = sum; // add
		endcase
	end

endmodule

`default_nettype wire

/* idu.sv */
`timescale 1ns/1ps
`default_nettype none

module idu (
	input  wire cpu_pkg::inst_word_u instr,
	output cpu_pkg::decoded_t        dec,
	output logic                     illegal
);

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        f7_zero;
	logic        f7_alt;

	assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
		instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	assign imm_u = {instr.u.imm, 12'b0};
	assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
		instr.j.imm11, instr.j.imm10_1, 1'b0};

	assign f7_zero = (instr.r.funct7 == 7'b0000000);
	assign f7_alt  = (instr.r.funct7 == 7'b0100000); // sub / sra

	always_comb begin
		dec           = '0;
		dec.rd        = instr.r.rd[3:0]; // rv32e has 16 regs
		dec.funct3    = instr.r.funct3;
		dec.funct7_b5 = instr.r.funct7[5];
		illegal       = 1'b0;
		case (instr.r.opcode)
			cpu_pkg::OPC_LUI: begin
				dec.inst_class[cpu_pkg::INST_LUI] = 1'b1;
				dec.imm                           = imm_u;
				dec.reg_wen                       = 1'b1;
			end
			cpu_pkg::OPC_AUIPC: begin
				dec.inst_class[cpu_pkg::INST_AUIPC] = 1'b1;
				dec.imm                             = imm_u;
				dec.reg_wen                         = 1'b1;
			end
			cpu_pkg::OPC_JAL: begin
				dec.inst_class[cpu_pkg::INST_JAL] = 1'b1;
				dec.imm                           = imm_j;
				dec.reg_wen                       = 1'b1;
			end
			cpu_pkg::OPC_JALR: begin
				dec.inst_class[cpu_pkg::INST_JALR] = 1'b1;
				dec.imm                            = imm_i;
				dec.reg_wen                        = 1'b1;
				illegal                            = (instr.i.funct3 != 3'b000);
			end
			cpu_pkg::OPC_BRANCH: begin
				dec.inst_class[cpu_pkg::INST_BRANCH] = 1'b1;
				dec.imm                              = imm_b;
				illegal = (instr.b.funct3 == 3'b010) || (instr.b.funct3 == 3'b011);
			end
			cpu_pkg::OPC_LOAD: begin
				dec.inst_class[cpu_pkg::INST_LW] = 1'b1;
				dec.imm                          = imm_i;
				dec.reg_wen                      = 1'b1;
				illegal                          = (instr.i.funct3 != 3'b010); // lw only
			end
			cpu_pkg::OPC_STORE: begin
				dec.inst_class[cpu_pkg::INST_SW] = 1'b1;
				dec.imm                          = imm_s;
				illegal                          = (instr.s.funct3 != 3'b010);
			end
			cpu_pkg::OPC_OPIMM: begin
				dec.inst_class[cpu_pkg::INST_OPIMM] = 1'b1;
				dec.imm                             = imm_i;
				dec.reg_wen                         = 1'b1;
				// shifts carry funct7 in the upper imm bits
				illegal = ((instr.i.funct3 == 3'b001) && !f7_zero) ||
					((instr.i.funct3 == 3'b101) && !(f7_zero || f7_alt));
			end
			cpu_pkg::OPC_OP: begin
				dec.inst_class[cpu_pkg::INST_OP] = 1'b1;
				dec.reg_wen                      = 1'b1;
				illegal = !(f7_zero || (f7_alt &&
					(instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101)));
			end
			cpu_pkg::OPC_SYSTEM: begin
				dec.inst_class[cpu_pkg::INST_CSR] = 1'b1;
				dec.imm                           = imm_i; // csr address
				if (instr.i.funct3 == 3'b001 || instr.i.funct3 == 3'b010) begin
					dec.reg_wen = 1'b1;
				end else if (instr == cpu_pkg::ECALL_WORD) begin
					dec.is_ecall = 1'b1;
				end else if (instr == cpu_pkg::MRET_WORD) begin
					dec.is_mret = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			dec.inst_class = '0;
			dec.reg_wen    = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// bit positions in the one-hot class vector
	localparam int NUM_CLASSES = 10;
	localparam int INST_LUI    = 0;
	localparam int INST_AUIPC  = 1;
	localparam int INST_JAL    = 2;
	localparam int INST_JALR   = 3;
	localparam int INST_BRANCH = 4;
	localparam int INST_LW     = 5;
	localparam int INST_SW     = 6;
	localparam int INST_OPIMM  = 7;
	localparam int INST_OP     = 8;
	localparam int INST_CSR    = 9;

	localparam logic [3:0] OP_ADD   = 4'd0;
	localparam logic [3:0] OP_SUB   = 4'd1;
	localparam logic [3:0] OP_AND   = 4'd2;
	localparam logic [3:0] OP_XOR   = 4'd3;
	localparam logic [3:0] OP_OR    = 4'd4;
	localparam logic [3:0] OP_SRL   = 4'd5;
	localparam logic [3:0] OP_SRA   = 4'd6;
	localparam logic [3:0] OP_SLL   = 4'd7;
	localparam logic [3:0] OP_LESS  = 4'd8;
	localparam logic [3:0] OP_ULESS = 4'd9;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
	localparam logic [31:0] MRET_WORD  = 32'h3020_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, read through each layout
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_word_u;

	typedef struct packed {
		logic [NUM_CLASSES-1:0] inst_class; // one-hot
		logic [3:0]             rd;
		logic [2:0]             funct3;
		logic                   funct7_b5;
		logic [31:0]            imm;
		logic                   reg_wen;
		logic                   is_ecall;
		logic                   is_mret;
	} decoded_t;

	typedef struct packed {
		logic [31:0] val;
		logic [31:0] csr_val;
		logic [31:0] pc;
		logic [31:0] csr_wdata;
		logic [31:0] lsu_data;
		logic [31:0] jump_addr;  // chosen next pc
		logic [3:0]  rd;
		logic [2:0]  funct3;
		logic [11:0] csr_imm;
		logic        reg_wen;
		logic        lsu_ren;
		logic        lsu_wen;
		logic        csr_enable;
		logic        jal_enable;
		logic        ecall;
	} exu_result_t;

endpackage

`default_nettype wire
